/* pipeCpu.f */
isaPkg.sv
pipePkg.sv
regFile.sv
decodeStage.sv
executeStage.sv
memoryStage.sv
pipeCpu.sv
pipeCpuChecker.sv
pipeCpuTb.sv

/* Bender.yml */
package:
  name: pipeCpu

sources:
  - isaPkg.sv
  - pipePkg.sv
  - regFile.sv
  - decodeStage.sv
  - executeStage.sv
  - memoryStage.sv
  - pipeCpu.sv
  - target: test
    files:
      - pipeCpuChecker.sv
      - pipeCpuTb.sv

/* pipeCpuTb.sv */
//******************************
// Testbench for the four-stage integer pipeline.
// Issues seeded random instruction streams, runs a
// reference model at issue and feeds the checker.
//******************************
module pipeCpuTb
	import isaPkg::*, pipePkg::*;
();

	localparam int resetSlots = 24;
	localparam int aluSlots = 200;
	localparam int memPairs = 80;
	localparam int bubbleSlots = 160;
	localparam int latencySlots = 120;
	localparam int numTests = 5;
	// Idle cycles allowed to drain the pipe, plus one for the end marker
	localparam int drainLimit = 6;
	localparam int cycleLimit = resetSlots + aluSlots + 2 * memPairs + bubbleSlots
		+ latencySlots + numTests * (drainLimit + 1) + 20;

	logic    clk;
	logic    rstN;
	logic    instValid;
	instr_t  instWord;
	wbPort_t wb;
	logic    expPush;
	regIdx_t expRd;
	data_t   expData;
	logic    testEnd;
	int      testNum;
	int      pending;
	int      testsDone;
	int      testsFailed;
	int      errorTotal;
	int      checkedTotal;
	logic    timedOut;
	data_t   modelRegs [regCount];
	data_t   modelMem [dmemWords];

	pipeCpu UUT (
		.clk       (clk),
		.rstN      (rstN),
		.instValid (instValid),
		.instWord  (instWord),
		.wb        (wb)
	);

	pipeCpuChecker monitor (
		.clk          (clk),
		.rstN         (rstN),
		.wb           (wb),
		.expPush      (expPush),
		.expRd        (expRd),
		.expData      (expData),
		.testEnd      (testEnd),
		.testNum      (testNum),
		.cycleLimit   (cycleLimit),
		.pending      (pending),
		.testsDone    (testsDone),
		.testsFailed  (testsFailed),
		.errorTotal   (errorTotal),
		.checkedTotal (checkedTotal),
		.timedOut     (timedOut)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Mostly r0..r3 so that close dependencies are common
	function automatic regIdx_t pickReg();
		if ($urandom % 4 != 0) begin
			return regIdx_t'($urandom % 4);
		end
		return regIdx_t'($urandom % regCount);
	endfunction

	function automatic aluFunc_t pickFunc();
		case ($urandom % 6)
			0: return fnAdd;
			1: return fnSub;
			2: return fnAnd;
			3: return fnOr;
			4: return fnXor;
			default: return fnSlt;
		endcase
	endfunction

	function automatic data_t signExtend(input logic [immWidth-1:0] imm);
		return data_t'($signed(imm));
	endfunction

	function automatic data_t aluModel(input aluFunc_t func, input data_t a, input data_t b);
		case (func)
			fnAdd: return a + b;
			fnSub: return a - b;
			fnAnd: return a & b;
			fnOr: return a | b;
			fnXor: return a ^ b;
			fnSlt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			default: return '0;
		endcase
	endfunction

	function automatic instr_t makeAlu();
		instr_t w;
		w = $urandom;
		w.r.func = pickFunc();
		w.r.rd = pickReg();
		w.r.rs1 = pickReg();
		if ($urandom % 2) begin
			w.r.opcode = opAluR;
			w.r.rs2 = pickReg();
		end else begin
			w.i.opcode = opAluI;
			// Small immediates make the signed compare interesting
			if ($urandom % 2) begin
				w.i.imm = 16'($urandom % 16) - 16'd8;
			end
		end
		return w;
	endfunction

	function automatic instr_t makeMem(input logic isLoad);
		instr_t w;
		w = $urandom;
		w.i.opcode = isLoad ? opLoad : opStore;
		w.i.rd = pickReg();
		w.i.rs1 = pickReg();
		w.i.imm = 16'(($urandom % 16) * 4);
		return w;
	endfunction

	function automatic instr_t makeNop();
		instr_t w;
		logic [3:0] code;
		w = $urandom;
		code = 4'($urandom);
		while (code inside {opAluR, opAluI, opLoad, opStore}) begin
			code = 4'($urandom);
		end
		w.r.opcode = opcode_t'(code);
		return w;
	endfunction

	function automatic instr_t makeAny();
		case ($urandom % 4)
			0: return makeMem(1'b1);
			1: return makeMem(1'b0);
			default: return makeAlu();
		endcase
	endfunction

	// Model runs in program order at issue, then the word goes out
	task automatic issueInstr(input instr_t w);
		data_t base;
		data_t addr;
		data_t result;
		logic  writes;
		writes = 1'b0;
		result = '0;
		base = modelRegs[w.r.rs1];
		addr = base + signExtend(w.i.imm);
		case (w.r.opcode)
			opAluR: begin
				result = aluModel(w.r.func, base, modelRegs[w.r.rs2]);
				writes = 1'b1;
			end
			opAluI: begin
				result = aluModel(w.i.func, base, signExtend(w.i.imm));
				writes = 1'b1;
			end
			opLoad: begin
				result = modelMem[addr[dmemAddrWidth+1:2]];
				writes = 1'b1;
			end
			opStore: modelMem[addr[dmemAddrWidth+1:2]] = modelRegs[w.r.rd];
			default: writes = 1'b0;
		endcase
		if (writes) begin
			modelRegs[w.r.rd] = result;
		end
		@(negedge clk);
		instValid = 1'b1;
		instWord = w;
		expPush = writes;
		expRd = w.r.rd;
		expData = result;
		testEnd = 1'b0;
	endtask

	// Bubble with a junk word on the bus
	task automatic idleSlot();
		@(negedge clk);
		instValid = 1'b0;
		instWord = $urandom;
		expPush = 1'b0;
		testEnd = 1'b0;
	endtask

	task automatic endTest(input int num);
		int waited;
		idleSlot();
		waited = 1;
		while (pending != 0 && waited < drainLimit) begin
			idleSlot();
			waited++;
		end
		@(negedge clk);
		instValid = 1'b0;
		expPush = 1'b0;
		testNum = num;
		testEnd = 1'b1;
	endtask

	initial begin
		wait (timedOut);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		instr_t w;
		instr_t first;
		instr_t second;
		rstN = 1'b0;
		instValid = 1'b0;
		instWord = '0;
		expPush = 1'b0;
		expRd = '0;
		expData = '0;
		testEnd = 1'b0;
		testNum = 0;
		void'($urandom(32'h9d56_146c));
		for (int idx = 0; idx < regCount; idx++) begin
			modelRegs[idx] = '0;
		end
		for (int idx = 0; idx < dmemWords; idx++) begin
			modelMem[idx] = '0;
		end
		repeat (5) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;

		$display("Starting test 1: reset state");
		repeat (resetSlots - regCount) idleSlot();
		for (int idx = 0; idx < regCount; idx++) begin
			w = '0;
			w.i.opcode = opAluI;
			w.i.func = fnAdd;
			w.i.rd = regIdx_t'(idx);
			w.i.rs1 = regIdx_t'(idx);
			issueInstr(w);
		end
		endTest(1);

		$display("Starting test 2: ALU operations");
		repeat (aluSlots) issueInstr(makeAlu());
		endTest(2);

		$display("Starting test 3: loads and stores");
		for (int idx = 0; idx < memPairs; idx++) begin
			first = makeMem(1'($urandom % 2));
			second = makeMem(1'b1);
			case ($urandom % 4)
				// Load right behind a store to the same address
				0: begin
					first.i.opcode = opStore;
					second.i.rs1 = first.i.rs1;
					second.i.imm = first.i.imm;
				end
				// Loaded value feeds the next instruction
				1: begin
					first.i.opcode = opLoad;
					second = makeAlu();
					second.r.rs1 = first.i.rd;
				end
				default: second = makeAny();
			endcase
			issueInstr(first);
			issueInstr(second);
		end
		endTest(3);

		$display("Starting test 4: bubbles and no-ops");
		for (int idx = 0; idx < bubbleSlots; idx++) begin
			case ($urandom % 8)
				0, 1: idleSlot();
				2: issueInstr(makeNop());
				3: issueInstr(makeAny());
				default: issueInstr(makeAlu());
			endcase
		end
		endTest(4);

		$display("Starting test 5: latency with sparse issue");
		for (int idx = 0; idx < latencySlots; idx++) begin
			if ($urandom % 2) begin
				issueInstr(makeAny());
			end else begin
				idleSlot();
			end
		end
		endTest(5);

		@(negedge clk);
		testEnd = 1'b0;
		$display("Totals: %0d of %0d tests failed, %0d writebacks checked, %0d errors",
			testsFailed, testsDone, checkedTotal, errorTotal);
		if (testsDone == numTests && testsFailed == 0 && errorTotal == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

/* pipeCpuChecker.sv */
//******************************
// Writeback checker for the pipeline testbench.
// Queues expected writebacks at capture, compares
// each wb beat, reports per test and times out.
//******************************
module pipeCpuChecker
	import isaPkg::*, pipePkg::*;
(
	input  logic    clk,
	input  logic    rstN,
	input  wbPort_t wb,
	input  logic    expPush,
	input  regIdx_t expRd,
	input  data_t   expData,
	input  logic    testEnd,
	input  int      testNum,
	input  int      cycleLimit,
	output int      pending,
	output int      testsDone,
	output int      testsFailed,
	output int      errorTotal,
	output int      checkedTotal,
	output logic    timedOut
);

	typedef struct packed {
		regIdx_t rd;
		data_t data;
		logic [31:0] due;
	} expect_t;

	expect_t expQ[$];
	int cycleCount;
	int testErrors;
	int testChecked;

	initial begin
		pending = 0;
		testsDone = 0;
		testsFailed = 0;
		errorTotal = 0;
		checkedTotal = 0;
		timedOut = 1'b0;
		cycleCount = 0;
		testErrors = 0;
		testChecked = 0;
	end

	task automatic countError();
		testErrors++;
		errorTotal++;
	endtask

	// Capture edge is sample c, wb is seen at sample c + 4
	task automatic recordExpected();
		expect_t entry;
		entry.rd = expRd;
		entry.data = expData;
		entry.due = cycleCount + 4;
		expQ.push_back(entry);
	endtask

	task automatic checkWriteback();
		expect_t entry;
		if (expQ.size() == 0) begin
			$display("Unexpected writeback to r%0d with data 0x%h at cycle %0d",
				wb.rd, wb.data, cycleCount);
			countError();
		end else begin
			entry = expQ.pop_front();
			testChecked++;
			checkedTotal++;
			if (cycleCount != entry.due) begin
				$display("Writeback for r%0d arrived at cycle %0d but was due at cycle %0d",
					entry.rd, cycleCount, entry.due);
				countError();
			end
			if (wb.rd !== entry.rd) begin
				$display("[ERROR] wb.rd: got 0x%h, expected 0x%h", wb.rd, entry.rd);
				countError();
			end
			if (wb.data !== entry.data) begin
				$display("[ERROR] wb.data: got 0x%h, expected 0x%h", wb.data, entry.data);
				countError();
			end
		end
	endtask

	task automatic finishTest();
		expect_t entry;
		while (expQ.size() > 0) begin
			entry = expQ.pop_front();
			$display("Writeback for r%0d due at cycle %0d never arrived", entry.rd, entry.due);
			countError();
		end
		testsDone++;
		if (testErrors != 0) begin
			testsFailed++;
		end
		$display("Test %0d: %0d writebacks checked, %0d errors, %s", testNum, testChecked,
			testErrors, (testErrors == 0) ? "passed" : "failed");
		testErrors = 0;
		testChecked = 0;
	endtask

	always @(posedge clk) begin
		if (!rstN) begin
			if (wb.valid === 1'b1) begin
				$display("Writeback valid while reset is asserted");
				countError();
			end
		end else begin
			if (wb.valid === 1'b1) begin
				checkWriteback();
			end else if (wb.valid !== 1'b0) begin
				$display("wb.valid is unknown at cycle %0d", cycleCount);
				countError();
			end
			if (expPush) begin
				recordExpected();
			end
			if (testEnd) begin
				finishTest();
			end
			pending = expQ.size();
			cycleCount++;
			if (cycleCount >= cycleLimit && !timedOut) begin
				$display("Timeout after %0d cycles, the run did not finish", cycleCount);
				timedOut = 1'b1;
			end
		end
	end

endmodule

/* pipeCpu.sv */
//******************************
// Four-stage integer pipeline top level.
// Instructions enter on a single-cycle strobe and
// results leave on the writeback port three edges later.
//******************************
module pipeCpu
	import isaPkg::*, pipePkg::*;
(
	input  logic    clk,
	input  logic    rstN,
	input  logic    instValid,
	input  instr_t  instWord,
	output wbPort_t wb
);

	regIdx_t  rdAddrA;
	regIdx_t  rdAddrB;
	data_t    rdDataA;
	data_t    rdDataB;
	decToEx_t decToEx;
	exToMe_t  exToMe;
	wbPort_t  meFwd;

	regFile regs (
		.clk     (clk),
		.rstN    (rstN),
		.rdAddrA (rdAddrA),
		.rdAddrB (rdAddrB),
		.rdDataA (rdDataA),
		.rdDataB (rdDataB),
		.wb      (wb)
	);

	decodeStage decode (
		.clk       (clk),
		.rstN      (rstN),
		.instValid (instValid),
		.instWord  (instWord),
		.rdAddrA   (rdAddrA),
		.rdAddrB   (rdAddrB),
		.rdDataA   (rdDataA),
		.rdDataB   (rdDataB),
		.decOut    (decToEx)
	);

	// Forwarding from memory stage and writeback
	executeStage execute (
		.clk   (clk),
		.rstN  (rstN),
		.decIn (decToEx),
		.meFwd (meFwd),
		.wb    (wb),
		.exOut (exToMe)
	);

	memoryStage memory (
		.clk   (clk),
		.rstN  (rstN),
		.exIn  (exToMe),
		.meFwd (meFwd),
		.wb    (wb)
	);

endmodule

/* memoryStage.sv */
//******************************
// Memory stage and writeback register.
// Data memory writes on stores and reads asynchronously;
// the selected result is forwarded, then registered as wb.
//******************************
module memoryStage
	import isaPkg::*, pipePkg::*;
(
	input  logic    clk,
	input  logic    rstN,
	input  exToMe_t exIn,
	output wbPort_t meFwd,
	output wbPort_t wb
);

	data_t dmem [dmemWords];
	logic [dmemAddrWidth-1:0] wordAddr;
	data_t loadData;

	// Word select from the byte address, upper bits ignored
	assign wordAddr = exIn.result[dmemAddrWidth+1:2];
	assign loadData = dmem[wordAddr];

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int idx = 0; idx < dmemWords; idx++) begin
				dmem[idx] <= '0;
			end
		end else if (exIn.valid && exIn.wrMem) begin
			dmem[wordAddr] <= exIn.storeData;
		end
	end

	always_comb begin
		meFwd.valid = exIn.valid && exIn.wrReg;
		meFwd.rd = exIn.rd;
		meFwd.data = exIn.memToReg ? loadData : exIn.result;
	end

	// Writeback register
	always_ff @(posedge clk) begin
		wb.rd <= meFwd.rd;
		wb.data <= meFwd.data;
		if (!rstN) begin
			wb.valid <= 1'b0;
		end else begin
			wb.valid <= meFwd.valid;
		end
	end

	storeNoWb: assert property (@(posedge clk) disable iff (!rstN)
		exIn.valid && exIn.wrMem |=> !wb.valid)
		else $error("store produced a register writeback");

endmodule

/* executeStage.sv */
//******************************
// Execute stage.
// Forwards operands from the memory stage and writeback,
// runs the ALU and registers the result for memory.
//******************************
module executeStage
	import isaPkg::*, pipePkg::*;
(
	input  logic     clk,
	input  logic     rstN,
	input  decToEx_t decIn,
	input  wbPort_t  meFwd,
	input  wbPort_t  wb,
	output exToMe_t  exOut
);

	data_t opA;
	data_t fwdB;
	data_t opB;
	data_t aluOut;
	logic  lessThan;

	// Youngest producer wins, then writeback, then the decoded value
	function automatic data_t pickOperand(
		input regIdx_t idx,
		input data_t regVal,
		input wbPort_t meSrc,
		input wbPort_t wbSrc
	);
		if (meSrc.valid && meSrc.rd == idx) begin
			return meSrc.data;
		end
		if (wbSrc.valid && wbSrc.rd == idx) begin
			return wbSrc.data;
		end
		return regVal;
	endfunction

	always_comb begin
		opA = pickOperand(decIn.rs1, decIn.valA, meFwd, wb);
		fwdB = pickOperand(decIn.srcB, decIn.valB, meFwd, wb);
		opB = decIn.ctrl.useImm ? decIn.imm : fwdB;
	end

	assign lessThan = $signed(opA) < $signed(opB);

	always_comb begin
		case (decIn.ctrl.aluFunc)
			fnAdd: aluOut = opA + opB;
			fnSub: aluOut = opA - opB;
			fnAnd: aluOut = opA & opB;
			fnOr: aluOut = opA | opB;
			fnXor: aluOut = opA ^ opB;
			// Condition flag, zero extended
			fnSlt: aluOut = {{(dataWidth - 1){1'b0}}, lessThan};
			default: aluOut = '0;
		endcase
	end

	// Execute pipeline register
	always_ff @(posedge clk) begin
		exOut.rd <= decIn.rd;
		exOut.result <= aluOut;
		// Store data goes through forwarding too
		exOut.storeData <= fwdB;
		if (!rstN) begin
			exOut.valid <= 1'b0;
			exOut.wrReg <= 1'b0;
			exOut.wrMem <= 1'b0;
			exOut.memToReg <= 1'b0;
		end else begin
			exOut.valid <= decIn.ctrl.valid;
			exOut.wrReg <= decIn.ctrl.wrReg;
			exOut.wrMem <= decIn.ctrl.wrMem;
			exOut.memToReg <= decIn.ctrl.memToReg;
		end
	end

endmodule

/* decodeStage.sv */
//******************************
// Instruction capture and decode.
// Captures the incoming word, reads the register file,
// builds control and registers it all for execute.
//******************************
module decodeStage
	import isaPkg::*, pipePkg::*;
(
	input  logic     clk,
	input  logic     rstN,
	input  logic     instValid,
	input  instr_t   instWord,
	output regIdx_t  rdAddrA,
	output regIdx_t  rdAddrB,
	input  data_t    rdDataA,
	input  data_t    rdDataB,
	output decToEx_t decOut
);

	logic   instValidQ;
	instr_t instQ;
	ctrl_t  ctrlNext;
	data_t  immExt;

	// Fetch capture register
	always_ff @(posedge clk) begin
		instQ <= instWord;
		if (!rstN) begin
			instValidQ <= 1'b0;
		end else begin
			instValidQ <= instValid;
		end
	end

	assign rdAddrA = instQ.r.rs1;
	// Stores fetch their data register on port B
	assign rdAddrB = (instQ.r.opcode == opStore) ? instQ.r.rd : instQ.r.rs2;
	assign immExt = {{(dataWidth - immWidth){instQ.i.imm[immWidth-1]}}, instQ.i.imm};

	always_comb begin
		ctrlNext = '0;
		case (instQ.r.opcode)
			opAluR: begin
				ctrlNext.wrReg = 1'b1;
				ctrlNext.aluFunc = instQ.r.func;
			end
			opAluI: begin
				ctrlNext.wrReg = 1'b1;
				ctrlNext.useImm = 1'b1;
				ctrlNext.aluFunc = instQ.i.func;
			end
			opLoad: begin
				ctrlNext.wrReg = 1'b1;
				ctrlNext.memToReg = 1'b1;
				ctrlNext.useImm = 1'b1;
				ctrlNext.aluFunc = fnAdd;
			end
			opStore: begin
				ctrlNext.wrMem = 1'b1;
				ctrlNext.useImm = 1'b1;
				ctrlNext.aluFunc = fnAdd;
			end
			default: ctrlNext = '0;
		endcase
		// A bubble carries no control at all
		ctrlNext.valid = instValidQ;
		if (!instValidQ) begin
			ctrlNext = '0;
		end
	end

	// Decode pipeline register
	always_ff @(posedge clk) begin
		decOut.rs1 <= instQ.r.rs1;
		decOut.srcB <= rdAddrB;
		decOut.rd <= instQ.r.rd;
		decOut.valA <= rdDataA;
		decOut.valB <= rdDataB;
		decOut.imm <= immExt;
		if (!rstN) begin
			decOut.ctrl <= '0;
		end else begin
			decOut.ctrl <= ctrlNext;
		end
	end

	nopNoWrite: assert property (@(posedge clk) disable iff (!rstN)
		instValidQ && !(instQ.r.opcode inside {opAluR, opAluI, opLoad, opStore})
		|=> !decOut.ctrl.wrReg && !decOut.ctrl.wrMem)
		else $error("no-op opcode raised a write enable");

endmodule

/* regFile.sv */
//******************************
// Sixteen-entry register file, two reads and one write.
// A write in the current cycle is bypassed to the
// readers so decode never sees stale data.
//******************************
module regFile
	import isaPkg::*, pipePkg::*;
(
	input  logic    clk,
	input  logic    rstN,
	input  regIdx_t rdAddrA,
	input  regIdx_t rdAddrB,
	output data_t   rdDataA,
	output data_t   rdDataB,
	input  wbPort_t wb
);

	data_t regs [regCount];

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int idx = 0; idx < regCount; idx++) begin
				regs[idx] <= '0;
			end
		end else if (wb.valid) begin
			regs[wb.rd] <= wb.data;
		end
	end

	// Write-through on a same-cycle read
	always_comb begin
		rdDataA = regs[rdAddrA];
		rdDataB = regs[rdAddrB];
		if (wb.valid && wb.rd == rdAddrA) begin
			rdDataA = wb.data;
		end
		if (wb.valid && wb.rd == rdAddrB) begin
			rdDataB = wb.data;
		end
	end

	wbAddrKnown: assert property (@(posedge clk) disable iff (!rstN)
		wb.valid |-> !$isunknown(wb.rd))
		else $error("regFile write with unknown address");

endmodule

/* pipePkg.sv */
//******************************
// Bundles passed between pipeline stages.
// Decode to execute, execute to memory, and the
// writeback port shared by regfile and forwarding.
//******************************
package pipePkg;

	import isaPkg::*;

	// Control bits generated in decode
	typedef struct packed {
		logic valid;
		logic wrReg;
		logic wrMem;
		logic memToReg;
		logic useImm;
		aluFunc_t aluFunc;
	} ctrl_t;

	// Decode pipeline register contents
	typedef struct packed {
		ctrl_t ctrl;
		regIdx_t rs1;
		// rs2 for register form, rd for stores
		regIdx_t srcB;
		regIdx_t rd;
		data_t valA;
		data_t valB;
		data_t imm;
	} decToEx_t;

	// Execute pipeline register contents
	typedef struct packed {
		logic valid;
		logic wrReg;
		logic wrMem;
		logic memToReg;
		regIdx_t rd;
		data_t result;
		data_t storeData;
	} exToMe_t;

	// Register write, valid only for instructions that write rd
	typedef struct packed {
		logic valid;
		regIdx_t rd;
		data_t data;
	} wbPort_t;

endpackage

/* isaPkg.sv */
//******************************
// Instruction set definitions for the integer pipeline.
// Widths, opcodes, ALU functions and the two instruction
// formats. Imported by every stage and by pipePkg.
//******************************
package isaPkg;

	localparam int dataWidth = 32;
	localparam int regIdxWidth = 4;
	localparam int regCount = 16;
	localparam int immWidth = 16;

	// Data memory is word addressed by byte address bits 9..2
	localparam int dmemWords = 256;
	localparam int dmemAddrWidth = 8;

	typedef logic [regIdxWidth-1:0] regIdx_t;
	typedef logic [dataWidth-1:0] data_t;

	// Any other encoding is a no-op
	typedef enum logic [3:0] {
		opAluR  = 4'b1100,
		opAluI  = 4'b0100,
		opLoad  = 4'b0111,
		opStore = 4'b0011
	} opcode_t;

	// Codes not listed produce a zero result
	typedef enum logic [3:0] {
		fnAnd = 4'b0000,
		fnOr  = 4'b0001,
		fnXor = 4'b0010,
		fnSub = 4'b0110,
		fnAdd = 4'b0111,
		fnSlt = 4'b1101
	} aluFunc_t;

	// Register form with the low 12 bits unused
	typedef struct packed {
		opcode_t opcode;
		aluFunc_t func;
		regIdx_t rd;
		regIdx_t rs1;
		regIdx_t rs2;
		logic [11:0] unused;
	} rForm_t;

	// Immediate form with a sign-extended immediate
	typedef struct packed {
		opcode_t opcode;
		aluFunc_t func;
		regIdx_t rd;
		regIdx_t rs1;
		logic [immWidth-1:0] imm;
	} iForm_t;

	// Same word seen through either format
	typedef union packed {
		rForm_t r;
		iForm_t i;
	} instr_t;

endpackage
